//--- Makefile
# Verilator build and run for the scope capture testbench

VERILATOR ?= verilator
TOP       ?= scope_dma_tb
FILELIST  ?= scope_dma.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
# Keep running after an assertion error so the testbench prints its summary
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/scope_dma_sva.sv
`default_nettype none

module scope_dma_sva
    import scope_regs_pkg::*;
    import scope_stream_pkg::*;
(
    input logic                      clock,
    input logic                      rst_n,
    input logic                      mem_valid,
    input logic                      mem_ready,
    input logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    input logic [WORD_WIDTH-1:0]     mem_data,
    input logic                      dma_done,
    input logic [N_TRIGGERS-1:0]     trigger_out
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of assertion failures, read by the testbench at the end of the run
    int unsigned failures = 0;

    // A stalled write keeps its slot, address and data until memory takes it
    stall_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data)
    ) else begin
        failures++;
        $error("memory write changed while stalled");
    end

    // At most one trigger line is active in any cycle
    trigger_one_hot: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0(trigger_out)
    ) else begin
        failures++;
        $error("more than one trigger line active");
    end

    // Frame end is only reported together with an accepted write
    done_on_write: assert property (
        @(posedge clock) disable iff (!rst_n)
        dma_done |-> mem_valid && mem_ready
    ) else begin
        failures++;
        $error("dma_done without an accepted write");
    end

endmodule

bind scope_dma scope_dma_sva protocol_checks (
    .clock(clock), .rst_n(rst_n),
    .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_data(mem_data),
    .dma_done(dma_done), .trigger_out(trigger_out)
);

`default_nettype wire

//--- bench/scope_dma_tb.sv
`default_nettype none

module scope_dma_tb
    import scope_regs_pkg::*;
    import scope_stream_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS = 4;
    localparam int TIMEOUT_CYCLES = 5000;
    // Cycles spent watching for stray writes before the acknowledge
    localparam int FREEZE_CYCLES = 16;

    logic                              clock;
    logic                              rst_n;
    logic                              reg_write;
    logic                              reg_read;
    logic [REG_ADDR_WIDTH-1:0]         reg_addr;
    logic [REG_WIDTH-1:0]              reg_wdata;
    logic [REG_WIDTH-1:0]              reg_rdata;
    logic [N_STREAMS-1:0]              stream_valid;
    logic [N_STREAMS-1:0]              stream_ready;
    logic [N_STREAMS*SAMPLE_WIDTH-1:0] stream_data;
    logic                              mem_valid;
    logic                              mem_ready;
    logic [MEM_ADDR_WIDTH-1:0]         mem_addr;
    logic [WORD_WIDTH-1:0]             mem_data;
    logic                              dma_done;
    logic [N_TRIGGERS-1:0]             trigger_out;

    // Table of tests with one array per column
    string test_name [N_TESTS] = '{"rotation", "trigger", "random_ready", "random_trigger"};
    int frame_len_tab [N_TESTS] = '{8, 6, 5, 7};
    logic [31:0] base_tab [N_TESTS] = '{32'h0000_1000, 32'h0000_2000,
                                        32'h3000_0040, 32'h0000_8000};
    bit use_trigger_tab [N_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    int select_tab [N_TESTS] = '{0, 5, 0, 2};
    int pos_tab [N_TESTS] = '{0, 3, 0, 4};
    int words_tab [N_TESTS] = '{32, 30, 40, 40};
    bit random_tab [N_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b1};

    logic [31:0] lfsr_state;

    // Source sequence numbers and the reference round-robin pointer
    int seq [N_STREAMS];
    int last_grant;
    logic [N_STREAMS-1:0] held;

    // Ordered list of the words the memory should see
    logic [WORD_WIDTH-1:0] expected_words [$];

    int cur;
    int taken;
    int write_offset;
    int trigger_pulses;
    int errors;
    int failed_tests;
    bit streaming;
    bit frozen;
    bit acked;
    bit trigger_seen;
    bit timed_out;

    // Register bus values for the next falling edge
    logic next_rst_n;
    logic next_write;
    logic next_read;
    logic [REG_ADDR_WIDTH-1:0] next_addr;
    logic [REG_WIDTH-1:0] next_wdata;

    scope_dma scope_dma_inst (
        .clock(clock), .rst_n(rst_n),
        .reg_write(reg_write), .reg_read(reg_read), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .stream_valid(stream_valid), .stream_ready(stream_ready), .stream_data(stream_data),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_data(mem_data), .dma_done(dma_done), .trigger_out(trigger_out)
    );

    always #20 clock = ~clock;

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1 that steps once per bit
    function automatic logic random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    // A source holds the channel times 4096 plus its sequence number
    function automatic logic [SAMPLE_WIDTH-1:0] sample_of(input int channel);
        return SAMPLE_WIDTH'(channel * 4096 + seq[channel]);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s %s: expected %08h, got %08h",
                     test_name[cur], what, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%s: %s", test_name[cur], what);
    endtask

    // Look at the values that the next rising edge will sample
    task automatic observe();
        logic [N_STREAMS-1:0] taken_now;
        logic [WORD_WIDTH-1:0] word;
        int grant;
        taken_now = stream_valid & stream_ready;
        // Round robin among the channels that offer data starts after the last grant
        grant = -1;
        for (int k = 1; k <= N_STREAMS; k++) begin
            if (grant < 0 && stream_valid[(last_grant + k) % N_STREAMS]) begin
                grant = (last_grant + k) % N_STREAMS;
            end
        end
        if (taken_now != '0) begin
            check_value("granted channel", 32'(1 << grant), 32'(taken_now));
            expected_words.push_back({DEST_WIDTH'(grant), sample_of(grant)});
            seq[grant]++;
            last_grant = grant;
            taken++;
        end
        held = stream_valid & ~taken_now;
        if (trigger_out != '0) begin
            trigger_pulses++;
            trigger_seen = 1'b1;
            check_value("trigger line",
                        use_trigger_tab[cur] ? 32'(1 << select_tab[cur]) : 32'h0,
                        32'(trigger_out));
            // One word may still sit in the engine, so the writes lag the level by one
            if (write_offset + 1 < pos_tab[cur]) begin
                report_problem("trigger fired before the buffer reached the trigger position");
            end
        end
        if (mem_valid && mem_ready) begin
            if (frozen) begin
                report_problem("memory write while capture is inhibited");
            end
            if (expected_words.size() == 0) begin
                report_problem("memory write with no sample pending");
            end else begin
                word = expected_words.pop_front();
                check_value("write data", word, mem_data);
                check_value("write address",
                            base_tab[cur] + 32'(write_offset * WORD_BYTES), mem_addr);
                check_value("frame end", 32'(write_offset == frame_len_tab[cur] - 1),
                            32'(dma_done));
                if (write_offset == frame_len_tab[cur] - 1) begin
                    write_offset = 0;
                    // The first frame end after the trigger closes the capture
                    if (use_trigger_tab[cur] && trigger_seen && !acked) begin
                        frozen = 1'b1;
                    end
                end else begin
                    write_offset++;
                end
            end
        end else if (dma_done) begin
            report_problem("dma_done without an accepted write");
        end
    endtask

    // One clock cycle that drives on the falling edge and then observes
    task automatic step();
        @(negedge clock);
        rst_n = next_rst_n;
        reg_write = next_write;
        reg_read = next_read;
        reg_addr = next_addr;
        reg_wdata = next_wdata;
        next_write = 1'b0;
        next_read = 1'b0;
        mem_ready = random_tab[cur] ? random_bit() : 1'b1;
        for (int c = 0; c < N_STREAMS; c++) begin
            // A source keeps its valid up until its handshake
            if (!held[c]) begin
                stream_valid[c] = streaming && (taken < words_tab[cur])
                                  && (random_tab[cur] ? random_bit() : 1'b1);
            end
            stream_data[c*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_of(c);
        end
        #1;
        observe();
    endtask

    task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        next_write = 1'b1;
        next_addr = addr;
        next_wdata = data;
        step();
    endtask

    // Read data is valid one cycle after the read strobe
    task automatic read_check(input string what, input logic [REG_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] expected);
        next_read = 1'b1;
        next_addr = addr;
        step();
        step();
        check_value(what, expected, reg_rdata);
    endtask

    task automatic run_test(input int t);
        int cycles;
        int freeze_count;
        int errors_before;
        cur = t;
        errors_before = errors;
        streaming = 1'b0;
        frozen = 1'b0;
        acked = 1'b0;
        trigger_seen = 1'b0;
        taken = 0;
        write_offset = 0;
        trigger_pulses = 0;
        last_grant = N_STREAMS - 1;
        held = '0;
        expected_words.delete();

        // Every test starts from reset
        next_rst_n = 1'b0;
        repeat (10) step();
        next_rst_n = 1'b1;
        step();

        write_reg(ADDR_FRAME_LEN, 32'(frame_len_tab[t]));
        write_reg(ADDR_BASE_ADDR, base_tab[t]);
        write_reg(ADDR_TRIGGER_POS, 32'(pos_tab[t]));
        if (use_trigger_tab[t]) begin
            write_reg(ADDR_TRIGGER_SELECT, 32'(select_tab[t]));
        end
        write_reg(ADDR_ENABLE, 32'd1);
        // The acknowledge register reads back as zero even right after a write
        write_reg(ADDR_CAPTURE_ACK, 32'hFFFF_FFFF);
        read_check("frame length", ADDR_FRAME_LEN, 32'(frame_len_tab[t]));
        read_check("base address", ADDR_BASE_ADDR, base_tab[t]);
        read_check("trigger position", ADDR_TRIGGER_POS, 32'(pos_tab[t]));
        read_check("trigger select", ADDR_TRIGGER_SELECT,
                   use_trigger_tab[t] ? 32'(select_tab[t]) : 32'h0);
        read_check("enable", ADDR_ENABLE, 32'd1);
        read_check("acknowledge", ADDR_CAPTURE_ACK, 32'h0);
        read_check("status after reset", ADDR_STATUS, 32'h0);

        streaming = 1'b1;
        cycles = 0;
        freeze_count = 0;
        while (!(taken >= words_tab[t] && held == '0 && expected_words.size() == 0
                 && (acked || !use_trigger_tab[t]))) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout in test %s: %0d samples taken, %0d writes outstanding",
                         test_name[t], taken, expected_words.size());
                timed_out = 1'b1;
                break;
            end
            step();
            cycles++;
            if (frozen) begin
                freeze_count++;
                if (freeze_count == FREEZE_CYCLES) begin
                    read_check("status while inhibited", ADDR_STATUS,
                               32'h8000_0000);
                    write_reg(ADDR_CAPTURE_ACK, 32'd1);
                    frozen = 1'b0;
                    acked = 1'b1;
                end
            end
        end
        streaming = 1'b0;

        if (!timed_out) begin
            // All accepted beats have gone through the frame counter by now
            read_check("status level", ADDR_STATUS, 32'(taken % frame_len_tab[t]));
            check_value("trigger pulses", use_trigger_tab[t] ? 32'd1 : 32'd0,
                        32'(trigger_pulses));
        end
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("%-15s %0d samples, %0d errors", test_name[t], taken, errors - errors_before);
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        reg_write = 1'b0;
        reg_read = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        stream_valid = '0;
        stream_data = '0;
        mem_ready = 1'b0;
        next_rst_n = 1'b0;
        next_write = 1'b0;
        next_read = 1'b0;
        next_addr = '0;
        next_wdata = '0;
        lfsr_state = 32'h657b8e88;
        for (int c = 0; c < N_STREAMS; c++) begin
            seq[c] = 0;
        end
        errors = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        cur = 0;

        for (int t = 0; t < N_TESTS && !timed_out; t++) begin
            run_test(t);
        end

        $display("tests %0d, with errors %0d, errors %0d, assertion failures %0d",
                 N_TESTS, failed_tests, errors, scope_dma_inst.protocol_checks.failures);
        if (errors == 0 && !timed_out && scope_dma_inst.protocol_checks.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/frame_marker.sv
`default_nettype none

module frame_marker
    import scope_regs_pkg::*;
    import scope_stream_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [LEVEL_WIDTH-1:0] frame_len,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [WORD_WIDTH-1:0]  in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [WORD_WIDTH-1:0]  out_data,
    output logic                   frame_last,
    output logic [LEVEL_WIDTH-1:0] buffer_level
);

    // Beats accepted so far in the current frame
    logic [LEVEL_WIDTH-1:0] beat_count;

    // The stream passes straight through with no added latency
    assign out_valid = in_valid;
    assign in_ready = out_ready;
    assign out_data = in_data;

    // Last beat of a frame, the count wraps after it
    assign frame_last = (beat_count == frame_len - LEVEL_WIDTH'(1));

    // The trigger looks at how far into the frame the capture is
    assign buffer_level = beat_count;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            beat_count <= '0;
        end else if (in_valid && out_ready) begin
            if (frame_last) begin
                beat_count <= '0;
            end else begin
                beat_count <= beat_count + LEVEL_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/scope_dma.sv
`default_nettype none

module scope_dma
    import scope_regs_pkg::*;
    import scope_stream_pkg::*;
(
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              reg_write,
    input  logic                              reg_read,
    input  logic [REG_ADDR_WIDTH-1:0]         reg_addr,
    input  logic [REG_WIDTH-1:0]              reg_wdata,
    output logic [REG_WIDTH-1:0]              reg_rdata,
    input  logic [N_STREAMS-1:0]              stream_valid,
    output logic [N_STREAMS-1:0]              stream_ready,
    input  logic [N_STREAMS*SAMPLE_WIDTH-1:0] stream_data,
    output logic                              mem_valid,
    input  logic                              mem_ready,
    output logic [MEM_ADDR_WIDTH-1:0]         mem_addr,
    output logic [WORD_WIDTH-1:0]             mem_data,
    output logic                              dma_done,
    output logic [N_TRIGGERS-1:0]             trigger_out
);

    // Configuration from the register file
    logic [LEVEL_WIDTH-1:0]       frame_len;
    logic                         dma_enable;
    logic [REG_WIDTH-1:0]         base_addr;
    logic [TRIGGER_SEL_WIDTH-1:0] trigger_select;
    logic                         trigger_arm;
    logic [LEVEL_WIDTH-1:0]       trigger_pos;
    logic                         capture_ack;
    logic                         capture_inhibit;

    // Combined stream before and after the inhibit gate
    logic                  comb_valid;
    logic                  comb_ready;
    logic [WORD_WIDTH-1:0] comb_data;
    logic                  gated_valid;
    logic                  gated_ready;

    // Framed stream into the engine
    logic                   marked_valid;
    logic                   marked_ready;
    logic [WORD_WIDTH-1:0]  marked_data;
    logic                   frame_last;
    logic [LEVEL_WIDTH-1:0] buffer_level;
    logic                   frame_done;

    // While inhibited the handshake is closed both ways so beats wait in the combiner
    assign gated_valid = comb_valid && !capture_inhibit;
    assign comb_ready = gated_ready && !capture_inhibit;

    // A frame is done when its last beat enters the engine
    assign frame_done = frame_last && marked_valid && marked_ready;

    scope_register_file register_file_inst (
        .clock(clock), .rst_n(rst_n),
        .reg_write(reg_write), .reg_read(reg_read), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .capture_inhibit(capture_inhibit), .buffer_level(buffer_level),
        .frame_len(frame_len), .dma_enable(dma_enable), .base_addr(base_addr),
        .trigger_select(trigger_select), .trigger_arm(trigger_arm),
        .trigger_pos(trigger_pos), .capture_ack(capture_ack)
    );

    trigger_hub trigger_hub_inst (
        .clock(clock), .rst_n(rst_n),
        .trigger_arm(trigger_arm), .trigger_select(trigger_select),
        .trigger_pos(trigger_pos), .buffer_level(buffer_level),
        .frame_done(frame_done), .capture_ack(capture_ack),
        .trigger_out(trigger_out), .capture_inhibit(capture_inhibit)
    );

    stream_combiner combiner_inst (
        .clock(clock), .rst_n(rst_n),
        .stream_valid(stream_valid), .stream_ready(stream_ready),
        .stream_data(stream_data),
        .comb_valid(comb_valid), .comb_ready(comb_ready), .comb_data(comb_data)
    );

    frame_marker frame_marker_inst (
        .clock(clock), .rst_n(rst_n), .frame_len(frame_len),
        .in_valid(gated_valid), .in_ready(gated_ready), .in_data(comb_data),
        .out_valid(marked_valid), .out_ready(marked_ready), .out_data(marked_data),
        .frame_last(frame_last), .buffer_level(buffer_level)
    );

    scope_dma_engine dma_engine_inst (
        .clock(clock), .rst_n(rst_n),
        .enable(dma_enable), .base_addr(base_addr),
        .in_valid(marked_valid), .in_ready(marked_ready), .in_data(marked_data),
        .in_last(frame_last),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_data(mem_data), .dma_done(dma_done)
    );

endmodule

`default_nettype wire

//--- hw/scope_dma_engine.sv
`default_nettype none

module scope_dma_engine
    import scope_stream_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [MEM_ADDR_WIDTH-1:0] base_addr,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [WORD_WIDTH-1:0]     in_data,
    input  logic                      in_last,
    output logic                      mem_valid,
    input  logic                      mem_ready,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic [WORD_WIDTH-1:0]     mem_data,
    output logic                      dma_done
);

    // Byte offset of the next word inside the current frame
    logic [MEM_ADDR_WIDTH-1:0] offset;

    // The word in the output slot closes a frame
    logic slot_last;

    // A beat enters the slot in this cycle
    logic accept;

    // Room in the slot when it is empty or the memory takes it now
    assign in_ready = enable && (!mem_valid || mem_ready);
    assign accept = in_valid && in_ready;

    // Frame end is reported when memory takes the last word
    assign dma_done = mem_valid && mem_ready && slot_last;

    // Slot valid and frame offset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            offset <= '0;
        end else if (accept) begin
            mem_valid <= 1'b1;
            if (in_last) begin
                offset <= '0;
            end else begin
                offset <= offset + MEM_ADDR_WIDTH'(WORD_BYTES);
            end
        end else if (mem_ready) begin
            mem_valid <= 1'b0;
        end
    end

    // Address and data only change on accept, so they hold through a stall
    always_ff @(posedge clock) begin
        if (accept) begin
            mem_addr <= base_addr + offset;
            mem_data <= in_data;
            slot_last <= in_last;
        end
    end

endmodule

`default_nettype wire

//--- hw/scope_register_file.sv
`default_nettype none

module scope_register_file
    import scope_regs_pkg::*;
(
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         reg_write,
    input  logic                         reg_read,
    input  logic [REG_ADDR_WIDTH-1:0]    reg_addr,
    input  logic [REG_WIDTH-1:0]         reg_wdata,
    output logic [REG_WIDTH-1:0]         reg_rdata,
    input  logic                         capture_inhibit,
    input  logic [LEVEL_WIDTH-1:0]       buffer_level,
    output logic [LEVEL_WIDTH-1:0]       frame_len,
    output logic                         dma_enable,
    output logic [REG_WIDTH-1:0]         base_addr,
    output logic [TRIGGER_SEL_WIDTH-1:0] trigger_select,
    output logic                         trigger_arm,
    output logic [LEVEL_WIDTH-1:0]       trigger_pos,
    output logic                         capture_ack
);

    // Read data selected by the address, registered on a read strobe
    logic [REG_WIDTH-1:0] read_word;

    // Writable registers and the two strobe pulses
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_len <= '0;
            dma_enable <= 1'b0;
            base_addr <= '0;
            trigger_select <= '0;
            trigger_pos <= '0;
            trigger_arm <= 1'b0;
            capture_ack <= 1'b0;
        end else begin
            // Arm and acknowledge are single cycle pulses
            trigger_arm <= reg_write && (reg_addr == ADDR_TRIGGER_SELECT);
            capture_ack <= reg_write && (reg_addr == ADDR_CAPTURE_ACK);
            if (reg_write) begin
                case (reg_addr)
                    ADDR_FRAME_LEN: frame_len <= reg_wdata[LEVEL_WIDTH-1:0];
                    ADDR_ENABLE: dma_enable <= reg_wdata[0];
                    ADDR_BASE_ADDR: base_addr <= reg_wdata;
                    ADDR_TRIGGER_SELECT: trigger_select <= reg_wdata[TRIGGER_SEL_WIDTH-1:0];
                    ADDR_TRIGGER_POS: trigger_pos <= reg_wdata[LEVEL_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Readback mux, narrow fields come back zero extended
    always_comb begin
        read_word = '0;
        case (reg_addr)
            ADDR_FRAME_LEN: read_word = REG_WIDTH'(frame_len);
            ADDR_ENABLE: read_word = REG_WIDTH'(dma_enable);
            ADDR_BASE_ADDR: read_word = base_addr;
            ADDR_TRIGGER_SELECT: read_word = REG_WIDTH'(trigger_select);
            ADDR_TRIGGER_POS: read_word = REG_WIDTH'(trigger_pos);
            ADDR_STATUS: begin
                read_word[STATUS_INHIBIT_BIT] = capture_inhibit;
                read_word[LEVEL_WIDTH-1:0] = buffer_level;
            end
            // The acknowledge register and unused indices read as zero
            default: read_word = '0;
        endcase
    end

    // Read data shows up one cycle after the strobe and holds until the next read
    always_ff @(posedge clock) begin
        if (reg_read) begin
            reg_rdata <= read_word;
        end
    end

endmodule

`default_nettype wire

//--- hw/scope_regs_pkg.sv
`default_nettype none

// Register map and field widths of the scope control port
package scope_regs_pkg;

    // Register index and data widths on the strobe bus
    localparam int REG_ADDR_WIDTH = 3;
    localparam int REG_WIDTH = 32;

    // Register indices
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_FRAME_LEN = 3'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_ENABLE = 3'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_BASE_ADDR = 3'd2;
    // A write here also arms the trigger
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TRIGGER_SELECT = 3'd3;
    // Write only, a write pulses the acknowledge
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CAPTURE_ACK = 3'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TRIGGER_POS = 3'd5;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_STATUS = 3'd6;

    // Status word layout, inhibit on top and buffer level in the low bits
    localparam int STATUS_INHIBIT_BIT = 31;
    localparam int LEVEL_WIDTH = 16;

    // Trigger lines and the width of the line selector
    localparam int N_TRIGGERS = 8;
    localparam int TRIGGER_SEL_WIDTH = 3;

endpackage

`default_nettype wire

//--- hw/scope_stream_pkg.sv
`default_nettype none

// Sizes of the sample streams and layout of the memory word
package scope_stream_pkg;

    // Number of input sample streams and their sample width
    localparam int N_STREAMS = 4;
    localparam int SAMPLE_WIDTH = 24;

    // Width of the round-robin channel index
    localparam int CHANNEL_WIDTH = $clog2(N_STREAMS);

    // The tag holds the channel index in the top bits of a word
    localparam int DEST_WIDTH = 8;

    // A memory word is the tag above the sample
    localparam int WORD_WIDTH = DEST_WIDTH + SAMPLE_WIDTH;

    // Byte addressing on the memory port
    localparam int MEM_ADDR_WIDTH = 32;
    localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

//--- hw/stream_combiner.sv
`default_nettype none

module stream_combiner
    import scope_stream_pkg::*;
(
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [N_STREAMS-1:0]              stream_valid,
    output logic [N_STREAMS-1:0]              stream_ready,
    input  logic [N_STREAMS*SAMPLE_WIDTH-1:0] stream_data,
    output logic                              comb_valid,
    input  logic                              comb_ready,
    output logic [WORD_WIDTH-1:0]             comb_data
);

    // Channel granted most recently, the search starts just after it
    logic [CHANNEL_WIDTH-1:0] last_grant;

    // Channel chosen in this cycle and whether any channel offers data
    logic [CHANNEL_WIDTH-1:0] grant_idx;
    logic                     grant_found;

    // Candidate channel during the round-robin search
    logic [CHANNEL_WIDTH-1:0] candidate;

    // The output slot can take a beat when it is empty or drains now
    logic slot_free;

    // A beat moves from the granted stream into the slot
    logic take;

    assign slot_free = !comb_valid || comb_ready;
    assign take = slot_free && grant_found;

    // Round-robin search over the channels after the last grant
    always_comb begin
        grant_found = 1'b0;
        grant_idx = last_grant;
        candidate = last_grant;
        for (int k = 1; k <= N_STREAMS; k++) begin
            candidate = CHANNEL_WIDTH'((int'(last_grant) + k) % N_STREAMS);
            if (!grant_found && stream_valid[candidate]) begin
                grant_found = 1'b1;
                grant_idx = candidate;
            end
        end
    end

    // Only the granted stream sees ready, and only while the slot has room
    always_comb begin
        stream_ready = '0;
        if (take) begin
            stream_ready[grant_idx] = 1'b1;
        end
    end

    // Output slot control and the round-robin pointer
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            comb_valid <= 1'b0;
            // Start just before channel 0 so the first grant goes to channel 0
            last_grant <= CHANNEL_WIDTH'(N_STREAMS - 1);
        end else if (take) begin
            comb_valid <= 1'b1;
            last_grant <= grant_idx;
        end else if (comb_ready) begin
            comb_valid <= 1'b0;
        end
    end

    // Tagged word, the channel index sits above the sample
    always_ff @(posedge clock) begin
        if (take) begin
            comb_data <= {DEST_WIDTH'(grant_idx),
                          stream_data[grant_idx*SAMPLE_WIDTH +: SAMPLE_WIDTH]};
        end
    end

endmodule

`default_nettype wire

//--- hw/trigger_hub.sv
`default_nettype none

module trigger_hub
    import scope_regs_pkg::*;
(
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         trigger_arm,
    input  logic [TRIGGER_SEL_WIDTH-1:0] trigger_select,
    input  logic [LEVEL_WIDTH-1:0]       trigger_pos,
    input  logic [LEVEL_WIDTH-1:0]       buffer_level,
    input  logic                         frame_done,
    input  logic                         capture_ack,
    output logic [N_TRIGGERS-1:0]        trigger_out,
    output logic                         capture_inhibit
);

    // An arm write leaves the trigger pending until the level condition holds
    logic pending;

    // Set once the trigger has fired, cleared by the acknowledge
    logic triggered;

    // The pending trigger fires when enough of the frame is in the buffer
    logic fire;

    assign fire = pending && (buffer_level >= trigger_pos);

    // Trigger line pulse, one hot on the selected line
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            trigger_out <= '0;
        end else begin
            trigger_out <= '0;
            if (fire) begin
                trigger_out[trigger_select] <= 1'b1;
            end
        end
    end

    // Arm state, a fresh arm write takes precedence over a fire in the same cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (trigger_arm) begin
            pending <= 1'b1;
        end else if (fire) begin
            pending <= 1'b0;
        end
    end

    // Triggered state and capture inhibit
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            triggered <= 1'b0;
            capture_inhibit <= 1'b0;
        end else if (capture_ack) begin
            // Software has read the frame, capture may go on
            triggered <= 1'b0;
            capture_inhibit <= 1'b0;
        end else begin
            if (fire) begin
                triggered <= 1'b1;
            end
            // The frame holding the trigger point is complete, freeze the buffer
            if (triggered && frame_done) begin
                capture_inhibit <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- scope_dma.f
hw/scope_regs_pkg.sv
hw/scope_stream_pkg.sv
hw/scope_register_file.sv
hw/trigger_hub.sv
hw/stream_combiner.sv
hw/frame_marker.sv
hw/scope_dma_engine.sv
hw/scope_dma.sv
bench/scope_dma_sva.sv
bench/scope_dma_tb.sv
